//--- verilog/shooter_pkg.sv
`default_nettype none

package shooter_pkg;

	typedef logic [7:0] row_t; // active low, one lit row
	typedef logic [3:0] col_t; // matrix column 8..15
	typedef logic [3:0] life_t;
	typedef logic [3:0] ammo_t;
	typedef logic [6:0] seg_t; // active low, a..g
	typedef logic [1:0] com_t;

	// scan order on the matrix
	typedef enum logic [2:0] {
		SLOT_A,
		SLOT_B,
		SLOT_A_UP,
		SLOT_A_DOWN,
		SLOT_B_UP,
		SLOT_B_DOWN
	} slot_t;

	localparam row_t ROW_EMPTY = 8'b1111_1111;
	localparam row_t ROW_TOP = 8'b1111_1110;
	localparam row_t ROW_BOTTOM = 8'b0111_1111;

	localparam col_t COL_MIN = 4'd8;
	localparam col_t COL_MAX = 4'd15;
	localparam col_t COL_START = 4'd12;

	localparam life_t LIFE_FULL = 4'd15;
	localparam ammo_t AMMO_FULL = 4'd9; // nine shots per player

	localparam com_t COM_A = 2'b01;
	localparam com_t COM_B = 2'b10;
	localparam seg_t SEG_BLANK = 7'b1111110; // only the middle bar lit

	// tick periods in CLK cycles
	localparam int MOVE_DIV_DEF = 20_000_000;
	localparam int SKILL_DIV_DEF = 3_000_000;
	localparam int SCAN_DIV_DEF = 20_000;

endpackage

`default_nettype wire

//--- verilog/tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
	parameter int MOVE_DIV = shooter_pkg::MOVE_DIV_DEF,
	parameter int SKILL_DIV = shooter_pkg::SKILL_DIV_DEF,
	parameter int SCAN_DIV = shooter_pkg::SCAN_DIV_DEF
) (
	input logic CLK,
	input logic Clear,
	output logic move_tick,
	output logic skill_tick,
	output logic scan_tick
);

	localparam int DIVS [0:2] = '{MOVE_DIV, SKILL_DIV, SCAN_DIV};

	logic [2:0] ticks;

	for (genvar i = 0; i < 3; i++)
	begin : g_div
		logic [31:0] cnt;

		// free running, strobe on terminal count
		always_ff @(posedge CLK or posedge Clear)
		begin
			if (Clear)
			begin
				cnt <= '0;
				ticks[i] <= 1'b0;
			end
			else if (cnt == 32'(DIVS[i] - 1))
			begin
				cnt <= '0;
				ticks[i] <= 1'b1;
			end
			else
			begin
				cnt <= cnt + 32'd1;
				ticks[i] <= 1'b0;
			end
		end
	end

	assign move_tick = ticks[0];
	assign skill_tick = ticks[1];
	assign scan_tick = ticks[2];

endmodule

`default_nettype wire

//--- verilog/player_move.sv
`timescale 1ns/1ns
`default_nettype none

module player_move #(
	parameter shooter_pkg::row_t START_ROW = shooter_pkg::ROW_BOTTOM
) (
	input logic CLK,
	input logic Clear,
	input logic move_tick,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	output shooter_pkg::row_t row,
	output shooter_pkg::col_t col
);

	import shooter_pkg::*;

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			row <= START_ROW;
			col <= COL_START;
		end
		else if (move_tick)
		begin
			// up wins over down
			if (up)
			begin
				if (row != ROW_TOP)
					row <= {1'b1, row[7:1]}; // toward bit 0
			end
			else if (down)
			begin
				if (row != ROW_BOTTOM)
					row <= {row[6:0], 1'b1};
			end

			// left wins over right
			if (left)
			begin
				if (col != COL_MIN)
					col <= col - 4'd1;
			end
			else if (right)
			begin
				if (col != COL_MAX)
					col <= col + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/shot_track.sv
`timescale 1ns/1ns
`default_nettype none

module shot_track (
	input logic CLK,
	input logic Clear,
	input logic skill_tick,
	input logic fire,
	input logic game_on,
	input shooter_pkg::row_t row,
	input shooter_pkg::col_t col,
	output shooter_pkg::row_t bullet_up,
	output shooter_pkg::row_t bullet_down,
	output shooter_pkg::col_t bullet_col,
	output shooter_pkg::ammo_t ammo
);

	import shooter_pkg::*;

	logic clear_sky; // no bullet of ours left on the matrix
	logic launch;

	assign clear_sky = (bullet_up == ROW_EMPTY) && (bullet_down == ROW_EMPTY);
	assign launch = fire && game_on && (ammo != 4'd0) && clear_sky;

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			bullet_up <= ROW_EMPTY;
			bullet_down <= ROW_EMPTY;
			bullet_col <= COL_START;
			ammo <= AMMO_FULL;
		end
		else if (skill_tick)
		begin
			if (launch)
			begin
				// start one step away from the player
				bullet_up <= {1'b1, row[7:1]};
				bullet_down <= {row[6:0], 1'b1};
				bullet_col <= col;
				ammo <= ammo - 4'd1;
			end
			else
			begin
				// 1 fill, so a bullet off the edge ends up empty
				bullet_up <= {1'b1, bullet_up[7:1]};
				bullet_down <= {bullet_down[6:0], 1'b1};
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/life_keeper.sv
`timescale 1ns/1ns
`default_nettype none

module life_keeper (
	input logic CLK,
	input logic Clear,
	input logic skill_tick,
	input shooter_pkg::row_t a_row,
	input shooter_pkg::row_t b_row,
	input shooter_pkg::col_t a_col,
	input shooter_pkg::col_t b_col,
	input shooter_pkg::row_t a_up,
	input shooter_pkg::row_t a_down,
	input shooter_pkg::row_t b_up,
	input shooter_pkg::row_t b_down,
	input shooter_pkg::col_t a_bullet_col,
	input shooter_pkg::col_t b_bullet_col,
	input logic a_defense,
	input logic b_defense,
	output shooter_pkg::life_t a_life,
	output shooter_pkg::life_t b_life,
	output logic game_on
);

	import shooter_pkg::*;

	logic a_hit; // B's bullets on A
	logic b_hit;

	assign a_hit = ((b_up == a_row) || (b_down == a_row)) && (b_bullet_col == a_col) && !a_defense;
	assign b_hit = ((a_up == b_row) || (a_down == b_row)) && (a_bullet_col == b_col) && !b_defense;

	assign game_on = (a_life != 4'd0) && (b_life != 4'd0);

	// lives freeze once either reaches zero
	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			a_life <= LIFE_FULL;
			b_life <= LIFE_FULL;
		end
		else if (skill_tick && game_on)
		begin
			if (a_hit)
				a_life <= a_life >> 1; // halve, round down
			if (b_hit)
				b_life <= b_life >> 1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/matrix_scan.sv
`timescale 1ns/1ns
`default_nettype none

module matrix_scan (
	input logic CLK,
	input logic Clear,
	input logic scan_tick,
	input logic game_on,
	input logic a_defense,
	input logic b_defense,
	input shooter_pkg::row_t a_row,
	input shooter_pkg::row_t b_row,
	input shooter_pkg::col_t a_col,
	input shooter_pkg::col_t b_col,
	input shooter_pkg::row_t a_up,
	input shooter_pkg::row_t a_down,
	input shooter_pkg::row_t b_up,
	input shooter_pkg::row_t b_down,
	input shooter_pkg::col_t a_bullet_col,
	input shooter_pkg::col_t b_bullet_col,
	output shooter_pkg::col_t column,
	output shooter_pkg::row_t r_color,
	output shooter_pkg::row_t g_color,
	output shooter_pkg::row_t b_color
);

	import shooter_pkg::*;

	slot_t slot;
	slot_t slot_next;
	col_t sel_col;
	row_t sel_r;
	row_t sel_g;
	row_t sel_b;

	// object and colors of the current slot
	always_comb
	begin
		sel_col = column;
		sel_r = ROW_EMPTY;
		sel_g = ROW_EMPTY;
		sel_b = ROW_EMPTY;
		slot_next = SLOT_A;
		case (slot)
			SLOT_A:
			begin
				sel_col = a_col;
				sel_r = a_row;
				if (a_defense) // white while defending
				begin
					sel_g = a_row;
					sel_b = a_row;
				end
				slot_next = SLOT_B;
			end
			SLOT_B:
			begin
				sel_col = b_col;
				sel_g = b_row;
				if (b_defense)
				begin
					sel_r = b_row;
					sel_b = b_row;
				end
				slot_next = SLOT_A_UP;
			end
			SLOT_A_UP:
			begin
				sel_col = a_bullet_col;
				sel_b = a_up;
				slot_next = SLOT_A_DOWN;
			end
			SLOT_A_DOWN:
			begin
				sel_col = a_bullet_col;
				sel_b = a_down;
				slot_next = SLOT_B_UP;
			end
			SLOT_B_UP:
			begin
				sel_col = b_bullet_col;
				sel_b = b_up;
				slot_next = SLOT_B_DOWN;
			end
			SLOT_B_DOWN:
			begin
				sel_col = b_bullet_col;
				sel_b = b_down;
				slot_next = SLOT_A; // wrap
			end
			default:
				slot_next = SLOT_A;
		endcase
	end

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			slot <= SLOT_A;
			column <= COL_START;
			r_color <= ROW_EMPTY;
			g_color <= ROW_EMPTY;
			b_color <= ROW_EMPTY;
		end
		else if (scan_tick)
		begin
			slot <= slot_next;
			if (game_on)
			begin
				column <= sel_col;
				r_color <= sel_r;
				g_color <= sel_g;
				b_color <= sel_b;
			end
			else
			begin
				// game over, dark matrix and column held
				r_color <= ROW_EMPTY;
				g_color <= ROW_EMPTY;
				b_color <= ROW_EMPTY;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/seg_mux.sv
`timescale 1ns/1ns
`default_nettype none

module seg_mux (
	input logic CLK,
	input logic Clear,
	input logic scan_tick,
	input shooter_pkg::ammo_t a_ammo,
	input shooter_pkg::ammo_t b_ammo,
	output shooter_pkg::seg_t seg,
	output shooter_pkg::com_t com
);

	import shooter_pkg::*;

	// a..g, active low
	localparam seg_t DIGITS [0:9] = '{
		7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110, 7'b1001100,
		7'b0100100, 7'b0100000, 7'b0001111, 7'b0000000, 7'b0000100
	};

	ammo_t digit;
	seg_t pattern;

	assign digit = (com == COM_A) ? a_ammo : b_ammo; // digit loaded on this tick

	always_comb
	begin
		if (digit > 4'd9)
			pattern = SEG_BLANK;
		else
			pattern = DIGITS[digit];
	end

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			seg <= SEG_BLANK;
			com <= COM_A;
		end
		else if (scan_tick)
		begin
			seg <= pattern;
			com <= (com == COM_A) ? COM_B : COM_A;
		end
	end

endmodule

`default_nettype wire

//--- verilog/shooter_top.sv
`timescale 1ns/1ns
`default_nettype none

module shooter_top #(
	parameter int MOVE_DIV = shooter_pkg::MOVE_DIV_DEF,
	parameter int SKILL_DIV = shooter_pkg::SKILL_DIV_DEF,
	parameter int SCAN_DIV = shooter_pkg::SCAN_DIV_DEF
) (
	input logic CLK,
	input logic Clear,
	input logic a_up,
	input logic a_down,
	input logic a_left,
	input logic a_right,
	input logic a_attack,
	input logic a_defense,
	input logic b_up,
	input logic b_down,
	input logic b_left,
	input logic b_right,
	input logic b_attack,
	input logic b_defense,
	output shooter_pkg::col_t column,
	output shooter_pkg::row_t r_color,
	output shooter_pkg::row_t g_color,
	output shooter_pkg::row_t b_color,
	output shooter_pkg::life_t a_life,
	output shooter_pkg::life_t b_life,
	output shooter_pkg::seg_t seg,
	output shooter_pkg::com_t com
);

	import shooter_pkg::*;

	logic move_tick;
	logic skill_tick;
	logic scan_tick;
	logic game_on;
	row_t a_row, b_row;
	col_t a_col, b_col;
	row_t a_shot_up, a_shot_down; // A's volley
	row_t b_shot_up, b_shot_down;
	col_t a_bullet_col, b_bullet_col;
	ammo_t a_ammo, b_ammo;

	tick_gen #(
		.MOVE_DIV(MOVE_DIV),
		.SKILL_DIV(SKILL_DIV),
		.SCAN_DIV(SCAN_DIV)
	) u_ticks (
		.CLK(CLK), .Clear(Clear),
		.move_tick(move_tick), .skill_tick(skill_tick), .scan_tick(scan_tick)
	);

	player_move #(.START_ROW(ROW_BOTTOM)) u_move_a (
		.CLK(CLK), .Clear(Clear), .move_tick(move_tick),
		.up(a_up), .down(a_down), .left(a_left), .right(a_right),
		.row(a_row), .col(a_col)
	);

	player_move #(.START_ROW(ROW_TOP)) u_move_b (
		.CLK(CLK), .Clear(Clear), .move_tick(move_tick),
		.up(b_up), .down(b_down), .left(b_left), .right(b_right),
		.row(b_row), .col(b_col)
	);

	shot_track u_shot_a (
		.CLK(CLK), .Clear(Clear), .skill_tick(skill_tick),
		.fire(a_attack), .game_on(game_on), .row(a_row), .col(a_col),
		.bullet_up(a_shot_up), .bullet_down(a_shot_down),
		.bullet_col(a_bullet_col), .ammo(a_ammo)
	);

	shot_track u_shot_b (
		.CLK(CLK), .Clear(Clear), .skill_tick(skill_tick),
		.fire(b_attack), .game_on(game_on), .row(b_row), .col(b_col),
		.bullet_up(b_shot_up), .bullet_down(b_shot_down),
		.bullet_col(b_bullet_col), .ammo(b_ammo)
	);

	life_keeper u_life (
		.CLK(CLK), .Clear(Clear), .skill_tick(skill_tick),
		.a_row(a_row), .b_row(b_row), .a_col(a_col), .b_col(b_col),
		.a_up(a_shot_up), .a_down(a_shot_down), .b_up(b_shot_up), .b_down(b_shot_down),
		.a_bullet_col(a_bullet_col), .b_bullet_col(b_bullet_col),
		.a_defense(a_defense), .b_defense(b_defense),
		.a_life(a_life), .b_life(b_life), .game_on(game_on)
	);

	matrix_scan u_scan (
		.CLK(CLK), .Clear(Clear), .scan_tick(scan_tick), .game_on(game_on),
		.a_defense(a_defense), .b_defense(b_defense),
		.a_row(a_row), .b_row(b_row), .a_col(a_col), .b_col(b_col),
		.a_up(a_shot_up), .a_down(a_shot_down), .b_up(b_shot_up), .b_down(b_shot_down),
		.a_bullet_col(a_bullet_col), .b_bullet_col(b_bullet_col),
		.column(column), .r_color(r_color), .g_color(g_color), .b_color(b_color)
	);

	seg_mux u_seg (
		.CLK(CLK), .Clear(Clear), .scan_tick(scan_tick),
		.a_ammo(a_ammo), .b_ammo(b_ammo), .seg(seg), .com(com)
	);

endmodule

`default_nettype wire

//--- tests/tb_shooter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_shooter;

	import shooter_pkg::*;

	// buttons are {up, down, left, right, attack, defense}
	typedef struct packed {
		logic [5:0] a_btn;
		logic [5:0] b_btn;
		logic on_skill; // count skill ticks instead of move ticks
		logic [7:0] ticks;
		ammo_t a_ammo;
		ammo_t b_ammo;
		life_t a_life;
		life_t b_life;
	} step_t;

	localparam int NSTEPS = 14;
	localparam int WAIT_MAX = 2000;

	logic CLK;
	logic Clear;
	logic [5:0] a_btn;
	logic [5:0] b_btn;
	col_t column;
	row_t r_color, g_color, b_color;
	life_t a_life, b_life;
	seg_t seg;
	com_t com;

	step_t steps [0:NSTEPS-1];
	int checks;
	int errors;
	logic [7:0] lfsr;
	int m_ridx [2]; // model row index with 0 at the top edge
	int m_col [2];

	shooter_top #(.MOVE_DIV(8), .SKILL_DIV(6), .SCAN_DIV(3)) u_dut (
		.CLK(CLK), .Clear(Clear),
		.a_up(a_btn[5]), .a_down(a_btn[4]), .a_left(a_btn[3]), .a_right(a_btn[2]),
		.a_attack(a_btn[1]), .a_defense(a_btn[0]),
		.b_up(b_btn[5]), .b_down(b_btn[4]), .b_left(b_btn[3]), .b_right(b_btn[2]),
		.b_attack(b_btn[1]), .b_defense(b_btn[0]),
		.column(column), .r_color(r_color), .g_color(g_color), .b_color(b_color),
		.a_life(a_life), .b_life(b_life), .seg(seg), .com(com)
	);

	always #2 CLK = ~CLK;

	task automatic check_row(input string what, input row_t got, input row_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_col(input string what, input col_t got, input col_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_life(input string what, input life_t got, input life_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_seg(input string what, input seg_t got, input seg_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_com(input string what, input com_t got, input com_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic abort(input string why);
		$display("%s at %0t, run stopped", why, $time);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// active-low seven-segment digits with bit 6 as segment a
	function automatic seg_t digit_seg(input ammo_t v);
		case (v)
			4'd0: digit_seg = 7'b0000001;
			4'd1: digit_seg = 7'b1001111;
			4'd2: digit_seg = 7'b0010010;
			4'd3: digit_seg = 7'b0000110;
			4'd4: digit_seg = 7'b1001100;
			4'd5: digit_seg = 7'b0100100;
			4'd6: digit_seg = 7'b0100000;
			4'd7: digit_seg = 7'b0001111;
			4'd8: digit_seg = 7'b0000000;
			4'd9: digit_seg = 7'b0000100;
			default: digit_seg = 7'b1111110;
		endcase
	endfunction

	function automatic row_t model_row(input int p);
		model_row = row_t'(~(8'b1 << m_ridx[p]));
	endfunction

	task automatic model_move(input int p, input logic [5:0] btn);
		if (btn[5] && m_ridx[p] > 0)
			m_ridx[p]--;
		else if (!btn[5] && btn[4] && m_ridx[p] < 7)
			m_ridx[p]++;
		if (btn[3] && m_col[p] > 8)
			m_col[p]--;
		else if (!btn[3] && btn[2] && m_col[p] < 15)
			m_col[p]++;
	endtask

	function automatic logic rand_bit();
		lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]}; // taps 8,6,5,4
		return lfsr[0];
	endfunction

	// the tick seen at the current falling edge counts as the first
	task automatic count_ticks(input logic on_skill, input int n);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		if (on_skill ? u_dut.skill_tick : u_dut.move_tick)
			seen++;
		while (seen < n)
		begin
			@(negedge CLK);
			cycles++;
			if (cycles > WAIT_MAX * n)
				abort("no tick strobe seen");
			if (on_skill ? u_dut.skill_tick : u_dut.move_tick)
				seen++;
		end
	endtask

	task automatic run_step(input logic [5:0] ab, input logic [5:0] bb, input logic on_skill,
			input int n);
		a_btn = ab;
		b_btn = bb;
		if (!on_skill)
			for (int k = 0; k < n; k++)
			begin
				model_move(0, ab);
				model_move(1, bb);
			end
		count_ticks(on_skill, n);
		@(negedge CLK);
		a_btn = ab & 6'b000001; // defense stays held until checked
		b_btn = bb & 6'b000001;
		count_ticks(1'b1, 10); // lets every bullet leave
	endtask

	task automatic read_player(input logic is_b, input logic white, output row_t row,
			output col_t col);
		int cycles;
		logic hit;
		cycles = 0;
		hit = 1'b0;
		while (!hit)
		begin
			@(negedge CLK);
			cycles++;
			if (cycles > WAIT_MAX)
				abort("player slot never showed on the matrix");
			if (white)
				hit = (r_color != ROW_EMPTY) && (g_color == r_color) && (b_color == r_color);
			else if (is_b)
				hit = (g_color != ROW_EMPTY) && (r_color == ROW_EMPTY) && (b_color == ROW_EMPTY);
			else
				hit = (r_color != ROW_EMPTY) && (g_color == ROW_EMPTY) && (b_color == ROW_EMPTY);
		end
		row = is_b ? g_color : r_color;
		col = column;
	endtask

	task automatic wait_com(input com_t want);
		int cycles;
		cycles = 0;
		while (com !== want)
		begin
			@(negedge CLK);
			cycles++;
			if (cycles > WAIT_MAX)
				abort("digit select stopped alternating");
		end
	endtask

	// AND of active-low rows keeps every lit row seen
	task automatic watch_colors(input logic dark);
		row_t acc_r, acc_g, acc_b;
		acc_r = ROW_EMPTY;
		acc_g = ROW_EMPTY;
		acc_b = ROW_EMPTY;
		repeat (72)
		begin
			@(negedge CLK);
			if (dark)
			begin
				acc_r &= r_color;
				acc_g &= g_color;
			end
			if (dark || (r_color == ROW_EMPTY && g_color == ROW_EMPTY))
				acc_b &= b_color;
		end
		if (dark)
		begin
			check_row("red after game over", acc_r, ROW_EMPTY);
			check_row("green after game over", acc_g, ROW_EMPTY);
		end
		check_row("blue slot", acc_b, ROW_EMPTY);
	endtask

	task automatic verify(input int idx, input ammo_t ea, input ammo_t eb, input life_t la,
			input life_t lb);
		row_t row;
		col_t col;
		if (la == 4'd0 || lb == 4'd0)
			watch_colors(1'b1);
		else
		begin
			read_player(1'b0, 1'b0, row, col);
			check_row("A row", row, model_row(0));
			check_col("A column", col, col_t'(m_col[0]));
			read_player(1'b1, b_btn[0], row, col);
			check_row("B row", row, model_row(1));
			check_col("B column", col, col_t'(m_col[1]));
			watch_colors(1'b0);
		end
		wait_com(COM_B); // seg now holds A's digit
		check_seg("A digit", seg, digit_seg(ea));
		wait_com(COM_A);
		check_seg("B digit", seg, digit_seg(eb));
		check_life("a_life", a_life, la);
		check_life("b_life", b_life, lb);
		a_btn = '0;
		b_btn = '0;
		$display("step %0d done, %0d errors so far", idx, errors);
	endtask

	initial
	begin
		logic [5:0] ab, bb;
		logic [1:0] t;
		CLK = 1'b0;
		Clear = 1'b1;
		a_btn = '0;
		b_btn = '0;
		checks = 0;
		errors = 0;
		lfsr = 8'd21;
		m_ridx = '{7, 0};
		m_col = '{12, 12};

		steps[0] = '{6'b000000, 6'b000000, 1'b0, 8'd1, 4'd9, 4'd9, 4'd15, 4'd15};
		steps[1] = '{6'b100000, 6'b010000, 1'b0, 8'd3, 4'd9, 4'd9, 4'd15, 4'd15};
		steps[2] = '{6'b111100, 6'b000100, 1'b0, 8'd10, 4'd9, 4'd9, 4'd15, 4'd15};
		steps[3] = '{6'b010100, 6'b101000, 1'b0, 8'd10, 4'd9, 4'd9, 4'd15, 4'd15};
		steps[4] = '{6'b011000, 6'b101000, 1'b0, 8'd8, 4'd9, 4'd9, 4'd15, 4'd15};
		steps[5] = '{6'b000000, 6'b000100, 1'b0, 8'd8, 4'd9, 4'd9, 4'd15, 4'd15};
		steps[6] = '{6'b000000, 6'b000010, 1'b1, 8'd90, 4'd9, 4'd0, 4'd15, 4'd15};
		steps[7] = '{6'b000000, 6'b001000, 1'b0, 8'd8, 4'd9, 4'd0, 4'd15, 4'd15};
		steps[8] = '{6'b000010, 6'b000000, 1'b1, 8'd1, 4'd8, 4'd0, 4'd15, 4'd7};
		steps[9] = '{6'b000010, 6'b000001, 1'b1, 8'd1, 4'd7, 4'd0, 4'd15, 4'd7};
		steps[10] = '{6'b000010, 6'b000000, 1'b1, 8'd9, 4'd5, 4'd0, 4'd15, 4'd1};
		steps[11] = '{6'b000010, 6'b000000, 1'b1, 8'd1, 4'd4, 4'd0, 4'd15, 4'd0};
		steps[12] = '{6'b000010, 6'b000010, 1'b1, 8'd1, 4'd4, 4'd0, 4'd15, 4'd0};
		steps[13] = '{6'b100000, 6'b000000, 1'b0, 8'd2, 4'd4, 4'd0, 4'd15, 4'd0};

		repeat (16) @(posedge CLK);
		@(negedge CLK);
		Clear = 1'b0;
		check_com("com after reset", com, COM_A);
		check_life("a_life after reset", a_life, LIFE_FULL);
		check_life("b_life after reset", b_life, LIFE_FULL);
		check_row("red after reset", r_color, ROW_EMPTY);
		check_row("green after reset", g_color, ROW_EMPTY);
		check_row("blue after reset", b_color, ROW_EMPTY);
		check_col("column after reset", column, COL_START);
		$display("reset test done, %0d errors so far", errors);

		for (int i = 0; i < NSTEPS; i++)
		begin
			if (i == 4)
				for (int r = 0; r < 8; r++)
				begin
					ab = '0;
					bb = '0;
					for (int b = 5; b >= 2; b--)
						ab[b] = rand_bit();
					for (int b = 5; b >= 2; b--)
						bb[b] = rand_bit();
					t[1] = rand_bit();
					t[0] = rand_bit();
					run_step(ab, bb, 1'b0, 1 + int'(t));
					verify(100 + r, 4'd9, 4'd9, 4'd15, 4'd15);
				end
			run_step(steps[i].a_btn, steps[i].b_btn, steps[i].on_skill, int'(steps[i].ticks));
			verify(i, steps[i].a_ammo, steps[i].b_ammo, steps[i].a_life, steps[i].b_life);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
verilog/shooter_pkg.sv
verilog/tick_gen.sv
verilog/player_move.sv
verilog/shot_track.sv
verilog/life_keeper.sv
verilog/matrix_scan.sv
verilog/seg_mux.sv
verilog/shooter_top.sv
tests/tb_shooter.sv

//--- Makefile
VERILATOR ?= verilator
FLIST ?= compile.f
TOP ?= tb_shooter
RTL_TOP ?= shooter_top
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS ?= --timescale 1ns/1ns

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
